//--- logic/core_pkg.sv
package core_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////
  parameter int inst_width     = 32;
  parameter int reg_addr_width = 5;
  parameter int num_regs       = 32;
  parameter int imm_width      = 16;

  // instruction word fields
  parameter int opcode_msb = 31;
  parameter int opcode_lsb = 26;
  parameter int rs_msb     = 25;
  parameter int rs_lsb     = 21;
  parameter int rt_msb     = 20;
  parameter int rt_lsb     = 16;
  parameter int rd_msb     = 15;
  parameter int rd_lsb     = 11;
  parameter int imm_msb    = 15;
  parameter int imm_lsb    = 0;

  //////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////
  // unlisted opcodes decode like op_nop
  typedef enum logic [5:0] {
    op_nop  = 6'd0,
    op_add  = 6'd1,
    op_sub  = 6'd2,
    op_and  = 6'd3,
    op_or   = 6'd4,
    op_xor  = 6'd5,
    op_slt  = 6'd6,
    op_addi = 6'd8,
    op_andi = 6'd12,
    op_ori  = 6'd13
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_xor = 3'd4,
    alu_slt = 3'd5
  } alu_op_e;

  typedef enum logic [1:0] {
    fwd_reg = 2'd0,
    fwd_ex  = 2'd1,
    fwd_wb  = 2'd2
  } fwd_sel_e;

endpackage

//--- logic/decode_stage.sv
`timescale 1ns/100ps

module decode_stage #(
  parameter int data_width = 32
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  instr_valid,
  input  logic [core_pkg::inst_width-1:0]       instr,
  input  logic [data_width-1:0]                 rs_data,
  input  logic [data_width-1:0]                 rt_data,
  output logic [core_pkg::reg_addr_width-1:0]   rs_addr,
  output logic [core_pkg::reg_addr_width-1:0]   rt_addr,
  output logic                                  d_valid,
  output core_pkg::alu_op_e                     d_alu_op,
  output logic                                  d_use_imm,
  output logic                                  d_write,
  output logic [core_pkg::reg_addr_width-1:0]   d_dest,
  output logic [core_pkg::reg_addr_width-1:0]   d_rs,
  output logic [core_pkg::reg_addr_width-1:0]   d_rt,
  output logic [data_width-1:0]                 d_rs_data,
  output logic [data_width-1:0]                 d_rt_data,
  output logic [core_pkg::imm_width-1:0]        d_imm
);

  logic                                i_valid;
  logic [core_pkg::inst_width-1:0]     i_instr;
  core_pkg::opcode_e                   opcode;
  logic [core_pkg::reg_addr_width-1:0] rd_field;
  core_pkg::alu_op_e                   dec_alu_op;
  logic                                dec_use_imm;
  logic                                dec_write;
  logic [core_pkg::reg_addr_width-1:0] dec_dest;

  // input latch
  always_ff @(posedge clk) begin
    if (rst) begin
      i_valid <= 1'b0;
    end else begin
      i_valid <= instr_valid;
    end
    if (instr_valid) begin
      i_instr <= instr;
    end
  end

  assign opcode   = core_pkg::opcode_e'(i_instr[core_pkg::opcode_msb:core_pkg::opcode_lsb]);
  assign rs_addr  = i_instr[core_pkg::rs_msb:core_pkg::rs_lsb];
  assign rt_addr  = i_instr[core_pkg::rt_msb:core_pkg::rt_lsb];
  assign rd_field = i_instr[core_pkg::rd_msb:core_pkg::rd_lsb];

  //////////////////////////////////////////////////
  // control decode
  //////////////////////////////////////////////////
  always_comb begin
    dec_alu_op  = core_pkg::alu_add;
    dec_use_imm = 1'b0;
    dec_write   = 1'b1;
    dec_dest    = rd_field;
    case (opcode)
      core_pkg::op_add:  dec_alu_op = core_pkg::alu_add;
      core_pkg::op_sub:  dec_alu_op = core_pkg::alu_sub;
      core_pkg::op_and:  dec_alu_op = core_pkg::alu_and;
      core_pkg::op_or:   dec_alu_op = core_pkg::alu_or;
      core_pkg::op_xor:  dec_alu_op = core_pkg::alu_xor;
      core_pkg::op_slt:  dec_alu_op = core_pkg::alu_slt;
      core_pkg::op_addi: begin
        dec_alu_op  = core_pkg::alu_add;
        dec_use_imm = 1'b1;
        dec_dest    = rt_addr;
      end
      core_pkg::op_andi: begin
        dec_alu_op  = core_pkg::alu_and;
        dec_use_imm = 1'b1;
        dec_dest    = rt_addr;
      end
      core_pkg::op_ori: begin
        dec_alu_op  = core_pkg::alu_or;
        dec_use_imm = 1'b1;
        dec_dest    = rt_addr;
      end
      default: dec_write = 1'b0;
    endcase
  end

  // decode register, r0 writes dropped here
  always_ff @(posedge clk) begin
    if (rst) begin
      d_valid <= 1'b0;
      d_write <= 1'b0;
    end else begin
      d_valid <= i_valid;
      d_write <= i_valid && dec_write && (dec_dest != '0);
    end
    d_alu_op  <= dec_alu_op;
    d_use_imm <= dec_use_imm;
    d_dest    <= dec_dest;
    d_rs      <= rs_addr;
    d_rt      <= rt_addr;
    d_rs_data <= rs_data;
    d_rt_data <= rt_data;
    d_imm     <= i_instr[core_pkg::imm_msb:core_pkg::imm_lsb];
  end

endmodule

//--- logic/register_file.sv
`timescale 1ns/100ps

module register_file #(
  parameter int data_width = 32
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [core_pkg::reg_addr_width-1:0] rs_addr,
  input  logic [core_pkg::reg_addr_width-1:0] rt_addr,
  input  logic                                w_write,
  input  logic [core_pkg::reg_addr_width-1:0] w_dest,
  input  logic [data_width-1:0]               w_result,
  output logic [data_width-1:0]               rs_data,
  output logic [data_width-1:0]               rt_data
);

  logic [data_width-1:0] regs [core_pkg::num_regs];
  logic                  wr_en;

  // r0 is never written so it stays zero
  assign wr_en = w_write && (w_dest != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < core_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[w_dest] <= w_result;
    end
  end

  //////////////////////////////////////////////////
  // read ports with write-through
  //////////////////////////////////////////////////
  always_comb begin
    if (wr_en && (w_dest == rs_addr)) begin
      rs_data = w_result;
    end else begin
      rs_data = regs[rs_addr];
    end
    if (wr_en && (w_dest == rt_addr)) begin
      rt_data = w_result;
    end else begin
      rt_data = regs[rt_addr];
    end
  end

endmodule

//--- logic/execute_stage.sv
`timescale 1ns/100ps

module execute_stage #(
  parameter int data_width = 32
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                d_valid,
  input  core_pkg::alu_op_e                   d_alu_op,
  input  logic                                d_use_imm,
  input  logic                                d_write,
  input  logic [core_pkg::reg_addr_width-1:0] d_dest,
  input  logic [core_pkg::reg_addr_width-1:0] d_rs,
  input  logic [core_pkg::reg_addr_width-1:0] d_rt,
  input  logic [data_width-1:0]               d_rs_data,
  input  logic [data_width-1:0]               d_rt_data,
  input  logic [core_pkg::imm_width-1:0]      d_imm,
  input  logic                                w_write,
  input  logic [core_pkg::reg_addr_width-1:0] w_dest,
  input  logic [data_width-1:0]               w_result,
  output logic                                x_valid,
  output logic                                x_write,
  output logic [core_pkg::reg_addr_width-1:0] x_dest,
  output logic [data_width-1:0]               x_result
);

  core_pkg::fwd_sel_e    rs_sel;
  core_pkg::fwd_sel_e    rt_sel;
  logic [data_width-1:0] op_a;
  logic [data_width-1:0] rt_val;
  logic [data_width-1:0] op_b;
  logic [data_width-1:0] alu_out;

  // youngest producer wins
  function automatic core_pkg::fwd_sel_e fwd_select(
    input logic [core_pkg::reg_addr_width-1:0] src
  );
    if (src == '0) begin
      return core_pkg::fwd_reg;
    end else if (x_write && (x_dest == src)) begin
      return core_pkg::fwd_ex;
    end else if (w_write && (w_dest == src)) begin
      return core_pkg::fwd_wb;
    end
    return core_pkg::fwd_reg;
  endfunction

  function automatic logic [data_width-1:0] fwd_pick(
    input core_pkg::fwd_sel_e    sel,
    input logic [data_width-1:0] reg_val
  );
    case (sel)
      core_pkg::fwd_ex: return x_result;
      core_pkg::fwd_wb: return w_result;
      default:          return reg_val;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // operands and ALU
  //////////////////////////////////////////////////
  always_comb begin
    rs_sel = fwd_select(d_rs);
    rt_sel = fwd_select(d_rt);
    op_a   = fwd_pick(rs_sel, d_rs_data);
    rt_val = fwd_pick(rt_sel, d_rt_data);
  end

  // zero-extended immediate
  assign op_b = d_use_imm ? data_width'(d_imm) : rt_val;

  always_comb begin
    case (d_alu_op)
      core_pkg::alu_add: alu_out = op_a + op_b;
      core_pkg::alu_sub: alu_out = op_a - op_b;
      core_pkg::alu_and: alu_out = op_a & op_b;
      core_pkg::alu_or:  alu_out = op_a | op_b;
      core_pkg::alu_xor: alu_out = op_a ^ op_b;
      core_pkg::alu_slt: alu_out = data_width'($signed(op_a) < $signed(op_b));
      default:           alu_out = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      x_valid <= 1'b0;
      x_write <= 1'b0;
    end else begin
      x_valid <= d_valid;
      x_write <= d_valid && d_write;
    end
    x_dest   <= d_dest;
    x_result <= alu_out;
  end

endmodule

//--- logic/writeback_stage.sv
`timescale 1ns/100ps

module writeback_stage #(
  parameter int data_width = 32
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                x_valid,
  input  logic                                x_write,
  input  logic [core_pkg::reg_addr_width-1:0] x_dest,
  input  logic [data_width-1:0]               x_result,
  output logic                                w_write,
  output logic [core_pkg::reg_addr_width-1:0] w_dest,
  output logic [data_width-1:0]               w_result,
  output logic                                wb_valid,
  output logic                                wb_write,
  output logic [core_pkg::reg_addr_width-1:0] wb_reg,
  output logic [data_width-1:0]               wb_data,
  output logic [31:0]                         retired_count
);

  logic w_valid;

  // last pipeline register, count moves with wb_valid
  always_ff @(posedge clk) begin
    if (rst) begin
      w_valid       <= 1'b0;
      w_write       <= 1'b0;
      retired_count <= '0;
    end else begin
      w_valid <= x_valid;
      w_write <= x_valid && x_write;
      if (x_valid) begin
        retired_count <= retired_count + 32'd1;
      end
    end
    w_dest   <= x_dest;
    w_result <= x_result;
  end

  //////////////////////////////////////////////////
  // retirement outputs
  //////////////////////////////////////////////////
  assign wb_valid = w_valid;
  assign wb_write = w_write;
  assign wb_reg   = w_dest;
  assign wb_data  = w_result;

endmodule

//--- logic/core_top.sv
`timescale 1ns/100ps

module core_top #(
  parameter int data_width = 32
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                instr_valid,
  input  logic [core_pkg::inst_width-1:0]     instr,
  output logic                                wb_valid,
  output logic                                wb_write,
  output logic [core_pkg::reg_addr_width-1:0] wb_reg,
  output logic [data_width-1:0]               wb_data,
  output logic [31:0]                         retired_count
);

  logic [core_pkg::reg_addr_width-1:0] rs_addr;
  logic [core_pkg::reg_addr_width-1:0] rt_addr;
  logic [data_width-1:0]               rs_data;
  logic [data_width-1:0]               rt_data;

  // decode register
  logic                                d_valid;
  core_pkg::alu_op_e                   d_alu_op;
  logic                                d_use_imm;
  logic                                d_write;
  logic [core_pkg::reg_addr_width-1:0] d_dest;
  logic [core_pkg::reg_addr_width-1:0] d_rs;
  logic [core_pkg::reg_addr_width-1:0] d_rt;
  logic [data_width-1:0]               d_rs_data;
  logic [data_width-1:0]               d_rt_data;
  logic [core_pkg::imm_width-1:0]      d_imm;

  // execute result
  logic                                x_valid;
  logic                                x_write;
  logic [core_pkg::reg_addr_width-1:0] x_dest;
  logic [data_width-1:0]               x_result;

  // writeback
  logic                                w_write;
  logic [core_pkg::reg_addr_width-1:0] w_dest;
  logic [data_width-1:0]               w_result;

  //////////////////////////////////////////////////
  // pipeline
  //////////////////////////////////////////////////
  decode_stage #(.data_width(data_width)) i_decode_stage (
    .clk, .rst, .instr_valid, .instr, .rs_data, .rt_data,
    .rs_addr, .rt_addr, .d_valid, .d_alu_op, .d_use_imm, .d_write,
    .d_dest, .d_rs, .d_rt, .d_rs_data, .d_rt_data, .d_imm
  );

  register_file #(.data_width(data_width)) i_register_file (
    .clk, .rst, .rs_addr, .rt_addr, .w_write, .w_dest, .w_result,
    .rs_data, .rt_data
  );

  execute_stage #(.data_width(data_width)) i_execute_stage (
    .clk, .rst, .d_valid, .d_alu_op, .d_use_imm, .d_write, .d_dest,
    .d_rs, .d_rt, .d_rs_data, .d_rt_data, .d_imm,
    .w_write, .w_dest, .w_result,
    .x_valid, .x_write, .x_dest, .x_result
  );

  writeback_stage #(.data_width(data_width)) i_writeback_stage (
    .clk, .rst, .x_valid, .x_write, .x_dest, .x_result,
    .w_write, .w_dest, .w_result,
    .wb_valid, .wb_write, .wb_reg, .wb_data, .retired_count
  );

endmodule

//--- tb/core_properties.sv
`timescale 1ns/100ps

module core_properties (
  input logic                                clk,
  input logic                                rst,
  input logic                                instr_valid,
  input logic                                wb_valid,
  input logic                                wb_write,
  input logic [core_pkg::reg_addr_width-1:0] wb_reg,
  input logic [31:0]                         retired_count
);

  // pipeline registers are clear one edge into reset
  quiet_in_reset: assert property (@(posedge clk) $past(rst) |-> !wb_valid)
    else $error("wb_valid high during reset");

  // three cycles of latency, seen one sample later
  latency_fwd: assert property (@(posedge clk) disable iff (rst) instr_valid |-> ##4 wb_valid)
    else $error("accepted instruction did not retire three cycles later");

  latency_back: assert property (@(posedge clk) disable iff (rst)
    wb_valid |-> $past(instr_valid, 4))
    else $error("wb_valid without an instruction accepted three cycles earlier");

  no_r0_write: assert property (@(posedge clk) disable iff (rst) wb_write |-> wb_reg != '0)
    else $error("wb_write high with wb_reg zero");

  count_step: assert property (@(posedge clk) disable iff (rst)
    !$past(rst) |-> retired_count == $past(retired_count) + (wb_valid ? 32'd1 : 32'd0))
    else $error("retired_count out of step with wb_valid");

endmodule

bind core_top core_properties i_core_properties (.*);

//--- tb/core_tb.sv
`timescale 1ns/100ps

module core_tb;

  typedef struct packed {
    logic [5:0]  op;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [15:0] imm;
    logic [3:0]  gap;
    logic [31:0] data;
  } step_t;

  localparam int num_steps  = 23;
  localparam int num_random = 200;
  localparam int wait_limit = 20;

  // op, rs, rt, rd, imm, idle cycles before, expected wb_data
  // data is ignored for op_nop and unknown opcodes
  localparam step_t steps [num_steps] = '{
    '{core_pkg::op_ori,  5'd0,  5'd1,  5'd0,  16'h1234, 4'd0, 32'h0000_1234},
    '{core_pkg::op_ori,  5'd0,  5'd2,  5'd0,  16'hffff, 4'd2, 32'h0000_ffff},
    '{core_pkg::op_addi, 5'd1,  5'd3,  5'd0,  16'h0010, 4'd3, 32'h0000_1244},
    '{core_pkg::op_andi, 5'd2,  5'd4,  5'd0,  16'h0f0f, 4'd4, 32'h0000_0f0f},
    '{core_pkg::op_ori,  5'd1,  5'd5,  5'd0,  16'h8000, 4'd0, 32'h0000_9234},
    '{core_pkg::op_sub,  5'd0,  5'd2,  5'd6,  16'h0000, 4'd0, 32'hffff_0001},
    '{core_pkg::op_add,  5'd6,  5'd6,  5'd7,  16'h0000, 4'd0, 32'hfffe_0002},
    '{core_pkg::op_add,  5'd6,  5'd2,  5'd8,  16'h0000, 4'd0, 32'h0000_0000},
    '{core_pkg::op_xor,  5'd7,  5'd6,  5'd9,  16'h0000, 4'd0, 32'h0001_0003},
    '{core_pkg::op_or,   5'd9,  5'd1,  5'd10, 16'h0000, 4'd0, 32'h0001_1237},
    '{core_pkg::op_slt,  5'd6,  5'd1,  5'd11, 16'h0000, 4'd0, 32'h0000_0001},
    '{core_pkg::op_slt,  5'd1,  5'd6,  5'd12, 16'h0000, 4'd1, 32'h0000_0000},
    '{core_pkg::op_slt,  5'd7,  5'd6,  5'd13, 16'h0000, 4'd0, 32'h0000_0001},
    '{core_pkg::op_addi, 5'd1,  5'd0,  5'd0,  16'h0005, 4'd0, 32'h0000_1239},
    '{core_pkg::op_add,  5'd0,  5'd1,  5'd14, 16'h0000, 4'd0, 32'h0000_1234},
    '{core_pkg::op_nop,  5'd1,  5'd2,  5'd3,  16'h0000, 4'd0, 32'h0000_0000},
    '{6'd7,              5'd1,  5'd2,  5'd15, 16'h0000, 4'd1, 32'h0000_0000},
    '{core_pkg::op_add,  5'd15, 5'd0,  5'd16, 16'h0000, 4'd0, 32'h0000_0000},
    '{core_pkg::op_sub,  5'd1,  5'd3,  5'd17, 16'h0000, 4'd2, 32'hffff_fff0},
    '{core_pkg::op_slt,  5'd17, 5'd0,  5'd18, 16'h0000, 4'd0, 32'h0000_0001},
    '{core_pkg::op_andi, 5'd17, 5'd19, 5'd0,  16'hff00, 4'd0, 32'h0000_ff00},
    '{core_pkg::op_addi, 5'd17, 5'd20, 5'd0,  16'h0001, 4'd0, 32'hffff_fff1},
    '{core_pkg::op_addi, 5'd20, 5'd21, 5'd0,  16'h000f, 4'd0, 32'h0000_0000}
  };

  logic        clk;
  logic        rst;
  logic        instr_valid;
  logic [31:0] instr;
  logic        wb_valid;
  logic        wb_write;
  logic [4:0]  wb_reg;
  logic [31:0] wb_data;
  logic [31:0] retired_count;

  logic [31:0] model_regs [32];
  logic [31:0] exp_data [$];
  logic        exp_write [$];
  logic [4:0]  exp_reg [$];
  logic        exp_check [$];
  int          exp_accept [$];
  logic [31:0] rng = 32'hace6;
  int          cycle = 0;
  int          errors = 0;

  core_top #(.data_width(32)) i_core_top (
    .clk, .rst, .instr_valid, .instr,
    .wb_valid, .wb_write, .wb_reg, .wb_data, .retired_count
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] alu_model(input logic [5:0] op, input logic [31:0] a,
                                            input logic [31:0] b, input logic [15:0] imm);
    case (op)
      core_pkg::op_add:  return a + b;
      core_pkg::op_sub:  return a - b;
      core_pkg::op_and:  return a & b;
      core_pkg::op_or:   return a | b;
      core_pkg::op_xor:  return a ^ b;
      core_pkg::op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      core_pkg::op_addi: return a + {16'h0000, imm};
      core_pkg::op_andi: return a & {16'h0000, imm};
      core_pkg::op_ori:  return a | {16'h0000, imm};
      default:           return 32'd0;
    endcase
  endfunction

  task automatic report_mismatch(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    errors++;
  endtask

  // waits the gap, then drives one instruction for a single cycle
  task automatic issue(input logic [5:0] op, input logic [4:0] rs, input logic [4:0] rt,
                       input logic [4:0] rd, input logic [15:0] imm, input int gap,
                       output logic known, output logic [31:0] result);
    logic       rtype;
    logic [4:0] dest;
    logic       wr;
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
    rtype = op inside {core_pkg::op_add, core_pkg::op_sub, core_pkg::op_and,
                       core_pkg::op_or, core_pkg::op_xor, core_pkg::op_slt};
    known = rtype || (op inside {core_pkg::op_addi, core_pkg::op_andi, core_pkg::op_ori});
    dest = rtype ? rd : rt;
    wr = known && (dest != 5'd0);
    result = alu_model(op, model_regs[rs], model_regs[rt], imm);
    if (wr) begin
      model_regs[dest] = result;
    end
    exp_data.push_back(result);
    exp_write.push_back(wr);
    exp_reg.push_back(dest);
    exp_check.push_back(known);
    exp_accept.push_back(cycle + 1);
    instr_valid = 1'b1;
    instr = {op, rs, rt, rtype ? {rd, 11'd0} : imm};
    @(posedge clk);
    #1;
    instr_valid = 1'b0;
  endtask

  task automatic run_table();
    logic        known;
    logic [31:0] result;
    for (int i = 0; i < num_steps; i++) begin
      issue(steps[i].op, steps[i].rs, steps[i].rt, steps[i].rd, steps[i].imm,
            int'(steps[i].gap), known, result);
      if (known) begin
        assert (result == steps[i].data)
          else report_mismatch($sformatf("step %0d: model gives %h, table expects %h",
                                         i, result, steps[i].data));
      end
    end
  endtask

  task automatic run_random();
    logic [5:0]  ops [11];
    logic        known;
    logic [31:0] result;
    logic [31:0] r;
    logic [31:0] r2;
    int          gap;
    int          idx;
    ops = '{core_pkg::op_add, core_pkg::op_sub, core_pkg::op_and, core_pkg::op_or,
            core_pkg::op_xor, core_pkg::op_slt, core_pkg::op_addi, core_pkg::op_andi,
            core_pkg::op_ori, core_pkg::op_nop, 6'd9};
    for (int i = 0; i < num_random; i++) begin
      rng = xorshift(rng);
      r = rng;
      rng = xorshift(rng);
      r2 = rng;
      // mostly back to back, small registers for dense dependences
      gap = (r[22:21] == 2'd0) ? int'(r[24:23]) : 0;
      idx = int'(r2 % 32'd11);
      issue(ops[idx], {2'b00, r[10:8]}, {2'b00, r[13:11]}, {2'b00, r[16:14]}, r2[31:16],
            gap, known, result);
    end
  endtask

  //////////////////////////////////////////////////
  // retirement checks
  //////////////////////////////////////////////////
  task automatic check_retirements(input int total);
    int          waited;
    int          accept;
    logic [31:0] data;
    logic        write;
    logic [4:0]  dest;
    logic        check;
    for (int n = 0; n < total; n++) begin
      waited = 0;
      do begin
        @(negedge clk);
        waited++;
      end while (!wb_valid && waited < wait_limit);
      if (!wb_valid) begin
        $display("timeout: no wb_valid within %0d cycles for instruction %0d", wait_limit, n);
        errors++;
        return;
      end
      if (exp_data.size() == 0) begin
        $display("wb_valid arrived with no instruction outstanding at %0t ns", $time);
        errors++;
        return;
      end
      data = exp_data.pop_front();
      write = exp_write.pop_front();
      dest = exp_reg.pop_front();
      check = exp_check.pop_front();
      accept = exp_accept.pop_front();
      assert (cycle - accept == 3)
        else report_mismatch($sformatf("instr %0d retired %0d cycles after acceptance",
                                       n, cycle - accept));
      assert (wb_write == write)
        else report_mismatch($sformatf("instr %0d wb_write %b, expected %b", n, wb_write, write));
      if (write) begin
        assert (wb_reg == dest)
          else report_mismatch($sformatf("instr %0d wb_reg %0d, expected %0d", n, wb_reg, dest));
      end
      if (check) begin
        assert (wb_data == data)
          else report_mismatch($sformatf("instr %0d wb_data %h, expected %h", n, wb_data, data));
      end
    end
  endtask

  initial begin
    rst = 1'b1;
    instr_valid = 1'b0;
    instr = '0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    fork
      begin
        run_table();
        run_random();
      end
      check_retirements(num_steps + num_random);
    join
    repeat (5) begin
      @(negedge clk);
      assert (!wb_valid) else report_mismatch("wb_valid after the last instruction");
    end
    assert (retired_count == 32'(num_steps + num_random))
      else report_mismatch($sformatf("retired_count %0d, expected %0d",
                                     retired_count, num_steps + num_random));
    $display("retirement checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- verilog.f
logic/core_pkg.sv
logic/decode_stage.sv
logic/register_file.sv
logic/execute_stage.sv
logic/writeback_stage.sv
logic/core_top.sv
tb/core_properties.sv
tb/core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := core_tb
FILELIST  := verilog.f
FLAGS     := --binary --timing --assert --timescale 1ns/100ps
BIN_DIR   := obj_dir
BIN       := $(BIN_DIR)/V$(TOP)
LOG       := sim.log
PASS_TEXT := PASS: all tests
SRCS      := $(filter %.sv %.v,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BIN_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BIN_DIR) $(LOG)
